/* Bender.yml */
package:
  name: ahb_gpio_sys

sources:
  # package first, then the RTL bottom up.
  - common/ahb_gpio_pkg.sv
  - hw/ahb_lite_decoder.sv
  - gpio/ahb_gpio_slave.sv
  - hw/ahb_ram_slave.sv
  - hw/ahb_slave_mux.sv
  - hw/ahb_gpio_sys.sv

  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_checker.sv
      - verif/tb_ahb_gpio_sys.sv

/* ahb_gpio_sys.f */
common/ahb_gpio_pkg.sv
hw/ahb_lite_decoder.sv
gpio/ahb_gpio_slave.sv
hw/ahb_ram_slave.sv
hw/ahb_slave_mux.sv
hw/ahb_gpio_sys.sv
verif/tb_clock_gen.sv
verif/tb_checker.sv
verif/tb_ahb_gpio_sys.sv

/* common/ahb_gpio_pkg.sv */
package ahb_gpio_pkg;

    // ########################################
    // ahb transfer types
    // ########################################

    localparam logic [1:0] htrans_idle   = 2'b00;
    localparam logic [1:0] htrans_busy   = 2'b01;
    localparam logic [1:0] htrans_nonseq = 2'b10;
    localparam logic [1:0] htrans_seq    = 2'b11;

    // ########################################
    // memory map
    // ########################################

    localparam logic [31:0] gpio_base   = 32'h1f80_0000;
    localparam logic [31:0] ram_base    = 32'h0000_0000;
    localparam logic [31:0] region_mask = 32'hfff0_0000;   // bits 31..20 select a region.

    // word address width of the gpio register file.
    localparam int reg_addr_width = 4;

    // ########################################
    // gpio register word indices
    // ########################################

    localparam logic [reg_addr_width-1:0] gpio_red_leds_idx   = 'd0;
    localparam logic [reg_addr_width-1:0] gpio_green_leds_idx = 'd1;
    localparam logic [reg_addr_width-1:0] gpio_hex_idx        = 'd2;
    localparam logic [reg_addr_width-1:0] gpio_switches_idx   = 'd3;
    localparam logic [reg_addr_width-1:0] gpio_buttons_idx    = 'd4;
    localparam logic [reg_addr_width-1:0] gpio_light_idx      = 'd5;

endpackage

/* gpio/ahb_gpio_slave.sv */
`timescale 1ns/1ps

module ahb_gpio_slave
    import ahb_gpio_pkg::*;
#(
    parameter int n_red_leds   = 18,
    parameter int n_green_leds = 8,
    parameter int n_switches   = 18,
    parameter int n_buttons    = 5,
    parameter int hex_width    = 32
)
(
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  logic [31:0]             haddr,
    input  logic [2:0]              hsize,
    input  logic [1:0]              htrans,
    input  logic                    hwrite,
    input  logic [31:0]             hwdata,
    input  logic                    hsel,
    input  logic                    hready_in,

    output logic [31:0]             hrdata,
    output logic                    hready_out,

    input  logic [n_switches-1:0]   switches,
    input  logic [n_buttons-1:0]    buttons,
    input  logic [15:0]             light_sensor,

    output logic [n_red_leds-1:0]   red_leds,
    output logic [n_green_leds-1:0] green_leds,
    output logic [hex_width-1:0]    hex_digits
);

    logic                      read_enable;
    logic [reg_addr_width-1:0] read_addr;
    logic                      write_enable;
    logic [reg_addr_width-1:0] write_addr;
    logic                      read_after_write;

    // stall for one cycle so the read sees the new register value.
    assign hready_out = !read_after_write;

    ahb_lite_decoder #(
        .addr_width       (reg_addr_width)
    ) decoder (
        .HCLK             (HCLK),
        .HRESETn          (HRESETn),
        .haddr            (haddr[reg_addr_width+1:0]),
        .hsize            (hsize),
        .htrans           (htrans),
        .hwrite           (hwrite),
        .hsel             (hsel),
        .hready_in        (hready_in),
        .read_enable      (read_enable),
        .read_addr        (read_addr),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_mask       (),                 // gpio writes are whole registers.
        .read_after_write (read_after_write)
    );

    // ########################################
    // output registers
    // ########################################

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            red_leds   <= '0;
            green_leds <= '0;
            hex_digits <= '0;
        end else if (write_enable) begin
            case (write_addr)
                gpio_red_leds_idx:   red_leds   <= hwdata[n_red_leds-1:0];
                gpio_green_leds_idx: green_leds <= hwdata[n_green_leds-1:0];
                gpio_hex_idx:        hex_digits <= hwdata[hex_width-1:0];
                default:             ;                  // inputs are read only.
            endcase
        end
    end

    // ########################################
    // read data
    // ########################################

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            hrdata <= 32'h0;
        end else if (read_enable) begin
            case (read_addr)
                gpio_red_leds_idx:   hrdata <= 32'(red_leds);
                gpio_green_leds_idx: hrdata <= 32'(green_leds);
                gpio_hex_idx:        hrdata <= 32'(hex_digits);
                gpio_switches_idx:   hrdata <= 32'(switches);
                gpio_buttons_idx:    hrdata <= 32'(buttons);
                gpio_light_idx:      hrdata <= 32'(light_sensor);
                default:             hrdata <= 32'h0;
            endcase
        end
    end

endmodule

/* hw/ahb_gpio_sys.sv */
`timescale 1ns/1ps

module ahb_gpio_sys #(
    parameter int n_red_leds     = 18,
    parameter int n_green_leds   = 8,
    parameter int n_switches     = 18,
    parameter int n_buttons      = 5,
    parameter int hex_width      = 32,
    parameter int ram_addr_width = 6
)
(
    input  logic                    HCLK,
    input  logic                    HRESETn,

    input  logic [31:0]             HADDR,
    input  logic [1:0]              HTRANS,
    input  logic [2:0]              HSIZE,
    input  logic                    HWRITE,
    input  logic [31:0]             HWDATA,
    input  logic [2:0]              HBURST,       // bursts run as single transfers.
    input  logic [3:0]              HPROT,
    input  logic                    HMASTLOCK,
    output logic [31:0]             HRDATA,
    output logic                    HREADY,
    output logic                    HRESP,

    input  logic [n_switches-1:0]   switches,
    input  logic [n_buttons-1:0]    buttons,
    input  logic [15:0]             light_sensor,
    output logic [n_red_leds-1:0]   red_leds,
    output logic [n_green_leds-1:0] green_leds,
    output logic [hex_width-1:0]    hex_digits
);

    logic        gpio_sel;
    logic        ram_sel;
    logic [31:0] gpio_rdata;
    logic        gpio_ready;
    logic [31:0] ram_rdata;
    logic        ram_ready;

    assign HRESP = 1'b0;   // always okay.

    ahb_slave_mux selector (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .haddr      (HADDR),
        .htrans     (HTRANS),
        .hready_in  (HREADY),
        .gpio_rdata (gpio_rdata),
        .gpio_ready (gpio_ready),
        .ram_rdata  (ram_rdata),
        .ram_ready  (ram_ready),
        .gpio_sel   (gpio_sel),
        .ram_sel    (ram_sel),
        .hrdata     (HRDATA),
        .hready     (HREADY)
    );

    ahb_gpio_slave #(
        .n_red_leds   (n_red_leds),
        .n_green_leds (n_green_leds),
        .n_switches   (n_switches),
        .n_buttons    (n_buttons),
        .hex_width    (hex_width)
    ) gpio (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .haddr        (HADDR),
        .hsize        (HSIZE),
        .htrans       (HTRANS),
        .hwrite       (HWRITE),
        .hwdata       (HWDATA),
        .hsel         (gpio_sel),
        .hready_in    (HREADY),
        .hrdata       (gpio_rdata),
        .hready_out   (gpio_ready),
        .switches     (switches),
        .buttons      (buttons),
        .light_sensor (light_sensor),
        .red_leds     (red_leds),
        .green_leds   (green_leds),
        .hex_digits   (hex_digits)
    );

    ahb_ram_slave #(
        .ram_addr_width (ram_addr_width)
    ) ram (
        .HCLK           (HCLK),
        .HRESETn        (HRESETn),
        .haddr          (HADDR),
        .hsize          (HSIZE),
        .htrans         (HTRANS),
        .hwrite         (HWRITE),
        .hwdata         (HWDATA),
        .hsel           (ram_sel),
        .hready_in      (HREADY),
        .hrdata         (ram_rdata),
        .hready_out     (ram_ready)
    );

endmodule

/* hw/ahb_lite_decoder.sv */
`timescale 1ns/1ps

module ahb_lite_decoder
    import ahb_gpio_pkg::*;
#(
    parameter int addr_width = 4
)
(
    input  logic                  HCLK,
    input  logic                  HRESETn,
    input  logic [addr_width+1:0] haddr,        // byte address inside the slave.
    input  logic [2:0]            hsize,
    input  logic [1:0]            htrans,
    input  logic                  hwrite,
    input  logic                  hsel,
    input  logic                  hready_in,

    output logic                  read_enable,
    output logic [addr_width-1:0] read_addr,
    output logic                  write_enable,
    output logic [addr_width-1:0] write_addr,
    output logic [3:0]            write_mask,
    output logic                  read_after_write
);

    logic       valid_xfer;
    logic       write_accept;
    logic       write_pending;
    logic [3:0] mask_next;

    assign valid_xfer   = hsel && (htrans == htrans_nonseq || htrans == htrans_seq);
    assign write_accept = valid_xfer && hwrite && hready_in;

    // reads go straight out in the address phase.
    assign read_enable = valid_xfer && !hwrite && hready_in;
    assign read_addr   = haddr[addr_width+1:2];

    // a read arriving while our own write is still in its data phase.
    assign read_after_write = valid_xfer && !hwrite && write_pending;

    assign write_enable = write_pending;

    always_comb begin
        case (hsize)
            3'd0:    mask_next = 4'b0001 << haddr[1:0];
            3'd1:    mask_next = haddr[1] ? 4'b1100 : 4'b0011;
            default: mask_next = 4'b1111;                       // word and wider.
        endcase
    end

    // ########################################
    // write address phase capture
    // ########################################

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            write_pending <= 1'b0;
        end else begin
            write_pending <= write_accept;   // one data phase per write.
        end
    end

    always_ff @(posedge HCLK) begin
        if (write_accept) begin
            write_addr <= haddr[addr_width+1:2];
            write_mask <= mask_next;
        end
    end

endmodule

/* hw/ahb_ram_slave.sv */
`timescale 1ns/1ps

module ahb_ram_slave #(
    parameter int ram_addr_width = 6
)
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic [31:0] haddr,
    input  logic [2:0]  hsize,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    input  logic        hsel,
    input  logic        hready_in,

    output logic [31:0] hrdata,
    output logic        hready_out
);

    localparam int n_words = 2 ** ram_addr_width;

    logic                      read_enable;
    logic [ram_addr_width-1:0] read_addr;
    logic                      write_enable;
    logic [ram_addr_width-1:0] write_addr;
    logic [3:0]                write_mask;
    logic                      read_after_write;

    logic [31:0] mem [n_words];

    assign hready_out = !read_after_write;

    ahb_lite_decoder #(
        .addr_width       (ram_addr_width)
    ) decoder (
        .HCLK             (HCLK),
        .HRESETn          (HRESETn),
        .haddr            (haddr[ram_addr_width+1:0]),
        .hsize            (hsize),
        .htrans           (htrans),
        .hwrite           (hwrite),
        .hsel             (hsel),
        .hready_in        (hready_in),
        .read_enable      (read_enable),
        .read_addr        (read_addr),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_mask       (write_mask),
        .read_after_write (read_after_write)
    );

    // ########################################
    // word array with byte lanes
    // ########################################

    always_ff @(posedge HCLK) begin
        if (write_enable) begin
            for (int i = 0; i < 4; i++) begin
                if (write_mask[i]) begin
                    mem[write_addr][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            hrdata <= 32'h0;
        end else if (read_enable) begin
            hrdata <= mem[read_addr];       // valid in the next data phase.
        end
    end

endmodule

/* hw/ahb_slave_mux.sv */
`timescale 1ns/1ps

module ahb_slave_mux
    import ahb_gpio_pkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic [31:0] haddr,
    input  logic [1:0]  htrans,
    input  logic        hready_in,

    input  logic [31:0] gpio_rdata,
    input  logic        gpio_ready,
    input  logic [31:0] ram_rdata,
    input  logic        ram_ready,

    output logic        gpio_sel,
    output logic        ram_sel,
    output logic [31:0] hrdata,
    output logic        hready
);

    logic active;
    logic owner_gpio;
    logic owner_ram;

    assign active = (htrans == htrans_nonseq) || (htrans == htrans_seq);

    // address phase decode.
    assign gpio_sel = (haddr & region_mask) == gpio_base;
    assign ram_sel  = (haddr & region_mask) == ram_base;

    // ########################################
    // data phase owner
    // ########################################

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            owner_gpio <= 1'b0;
            owner_ram  <= 1'b0;
        end else if (hready_in) begin
            owner_gpio <= active && gpio_sel;
            owner_ram  <= active && ram_sel;
        end
    end

    // unmapped or idle data phases finish at once with zero data.
    always_comb begin
        if (owner_gpio) begin
            hrdata = gpio_rdata;
            hready = gpio_ready;
        end else if (owner_ram) begin
            hrdata = ram_rdata;
            hready = ram_ready;
        end else begin
            hrdata = 32'h0;
            hready = 1'b1;
        end
    end

endmodule

/* verif/tb_ahb_gpio_sys.sv */
`timescale 1ns/1ps

module tb_ahb_gpio_sys
    import ahb_gpio_pkg::*;
;

    localparam int n_red_leds     = 18;
    localparam int n_green_leds   = 8;
    localparam int n_switches     = 18;
    localparam int n_buttons      = 5;
    localparam int hex_width      = 32;
    localparam int ram_addr_width = 6;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [2:0]  size;
        logic [31:0] wdata;
        logic [31:0] exp_data;   // read data, or pin value after a gpio write.
        logic        check;
    } entry_t;

    logic HCLK, HRESETn;
    logic [31:0] HADDR, HWDATA, HRDATA, exp_rdata;
    logic [1:0]  HTRANS;
    logic [2:0]  HSIZE, HBURST;
    logic [3:0]  HPROT;
    logic        HWRITE, HMASTLOCK, HREADY, HRESP, exp_check;
    logic [n_switches-1:0]   switches;
    logic [n_buttons-1:0]    buttons;
    logic [15:0]             light_sensor;
    logic [n_red_leds-1:0]   red_leds;
    logic [n_green_leds-1:0] green_leds;
    logic [hex_width-1:0]    hex_digits;
    int     tests_done, tests_failed, limit;
    int     cycles = 0;
    entry_t xfers[$];

    tb_clock_gen #(.period_ns(40), .reset_cycles(2)) clock_gen (.HCLK(HCLK), .HRESETn(HRESETn));

    ahb_gpio_sys #(
        .n_red_leds(n_red_leds), .n_green_leds(n_green_leds), .n_switches(n_switches),
        .n_buttons(n_buttons), .hex_width(hex_width), .ram_addr_width(ram_addr_width)
    ) uut (.*);

    tb_checker #(
        .n_red_leds(n_red_leds), .n_green_leds(n_green_leds), .hex_width(hex_width)
    ) scoreboard (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        lcg_next = state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] gpio_reg(input logic [reg_addr_width-1:0] idx);
        gpio_reg = gpio_base + {idx, 2'b00};
    endfunction

    function automatic void add_entry(input logic w, input logic [31:0] addr,
                                      input logic [2:0] size, input logic [31:0] wdata,
                                      input logic [31:0] exp_data, input logic check);
        entry_t e;
        e = {w, addr, size, wdata, exp_data, check};
        xfers.push_back(e);
    endfunction

    // ########################################
    // transfer table
    // ########################################

    task automatic load_table;
        add_entry(0, gpio_reg(gpio_red_leds_idx),   2, 0, 32'h0, 1);  // reset state.
        add_entry(0, gpio_reg(gpio_green_leds_idx), 2, 0, 32'h0, 0);
        add_entry(0, gpio_reg(gpio_hex_idx),        2, 0, 32'h0, 0);
        add_entry(1, gpio_reg(gpio_red_leds_idx),   2, 32'hffff_ffff, 32'h0003_ffff, 1);
        add_entry(1, gpio_reg(gpio_green_leds_idx), 2, 32'h1234_56a5, 32'h0000_00a5, 1);
        add_entry(1, gpio_reg(gpio_hex_idx),        2, 32'hdead_beef, 32'hdead_beef, 1);
        add_entry(0, gpio_reg(gpio_red_leds_idx),   2, 0, 32'h0003_ffff, 0);
        add_entry(0, gpio_reg(gpio_green_leds_idx), 2, 0, 32'h0000_00a5, 0);
        add_entry(0, gpio_reg(gpio_hex_idx),        2, 0, 32'hdead_beef, 0);
        add_entry(0, gpio_reg(gpio_switches_idx),   2, 0, 32'h0, 0);  // from the pins.
        add_entry(0, gpio_reg(gpio_buttons_idx),    2, 0, 32'h0, 0);
        add_entry(0, gpio_reg(gpio_light_idx),      2, 0, 32'h0, 0);
        add_entry(0, gpio_reg(4'd7),  2, 0, 32'h0, 0);
        add_entry(0, gpio_reg(4'd15), 2, 0, 32'h0, 0);
        add_entry(1, ram_base + 32'h10, 2, 32'h1122_3344, 32'h0, 0);
        add_entry(1, ram_base + 32'h11, 0, 32'h0000_aa00, 32'h0, 0);
        add_entry(1, ram_base + 32'h12, 1, 32'hbeef_0000, 32'h0, 0);
        add_entry(0, ram_base + 32'h10, 2, 0, 32'hbeef_aa44, 0);
        add_entry(1, ram_base + 32'h20, 2, 32'hcafe_f00d, 32'h0, 0);
        add_entry(1, ram_base + 32'h23, 0, 32'h5a00_0000, 32'h0, 0);
        add_entry(1, ram_base + 32'h20, 1, 32'h0000_1234, 32'h0, 0);
        add_entry(0, ram_base + 32'h20, 2, 0, 32'h5afe_1234, 0);
        add_entry(1, gpio_reg(gpio_green_leds_idx), 2, 32'h0000_003c, 32'h0000_003c, 1);
        add_entry(0, gpio_reg(gpio_green_leds_idx), 2, 0, 32'h0000_003c, 0);
        add_entry(1, ram_base + 32'h30, 2, 32'h0bad_cafe, 32'h0, 0);
        add_entry(0, ram_base + 32'h30, 2, 0, 32'h0bad_cafe, 0);
        add_entry(1, 32'h3000_0000, 2, 32'h0001_5a5a, 32'h0, 1);        // outside both regions.
        add_entry(0, 32'h3000_0004, 2, 0, 32'h0, 1);
        add_entry(0, ram_base + 32'h10, 2, 0, 32'hbeef_aa44, 0);
    endtask

    task automatic wait_ready;
        @(negedge HCLK);
        while (HREADY !== 1'b1) @(negedge HCLK);
    endtask

    // ########################################
    // pipelined master
    // ########################################

    initial begin
        entry_t e, prev;
        logic [31:0] rnd, exp;
        logic [reg_addr_width-1:0] idx;
        logic [n_switches-1:0] sw_val;
        logic [n_buttons-1:0]  btn_val;
        logic [15:0]           light_val;
        HADDR = 32'h0;
        HTRANS = htrans_idle;
        HSIZE = 3'd2;
        HWRITE = 1'b0;
        HWDATA = 32'h0;
        HBURST = 3'd0;
        HPROT = 4'b0011;
        HMASTLOCK = 1'b0;
        exp_rdata = 32'h0;
        exp_check = 1'b0;
        load_table();
        limit = 4 * xfers.size() + 20;
        rnd = lcg_next(32'd47);
        switches = rnd[31 -: n_switches];
        buttons = rnd[n_buttons-1:0];
        light_sensor = rnd[23:8];
        prev = '0;
        wait (HRESETn === 1'b1);
        for (int i = 0; i < xfers.size(); i++) begin
            e = xfers[i];
            exp = e.exp_data;
            idx = e.addr[reg_addr_width+1:2];
            @(posedge HCLK);
            if (!e.write && (e.addr & region_mask) == gpio_base &&
                (idx == gpio_switches_idx || idx == gpio_buttons_idx ||
                 idx == gpio_light_idx)) begin
                rnd = lcg_next(rnd);
                sw_val = rnd[31 -: n_switches];
                rnd = lcg_next(rnd);
                btn_val = rnd[31 -: n_buttons];
                rnd = lcg_next(rnd);
                light_val = rnd[31 -: 16];
                switches <= sw_val;
                buttons <= btn_val;
                light_sensor <= light_val;              // held until the next pin read.
                exp = (idx == gpio_switches_idx) ? 32'(sw_val) :
                      (idx == gpio_buttons_idx)  ? 32'(btn_val) : 32'(light_val);
            end
            HADDR <= e.addr;
            HTRANS <= htrans_nonseq;
            HWRITE <= e.write;
            HSIZE <= e.size;
            HWDATA <= prev.write ? prev.wdata : 32'h0;  // data of the previous address.
            exp_rdata <= exp;
            exp_check <= e.check;
            prev = e;
            wait_ready();
        end
        @(posedge HCLK);
        HTRANS <= htrans_idle;
        HWRITE <= 1'b0;
        HWDATA <= prev.write ? prev.wdata : 32'h0;
        exp_check <= 1'b0;
        wait_ready();
        while (tests_done < xfers.size()) @(posedge HCLK);
        $display("%0d tests, %0d passed, %0d failed", tests_done, tests_done - tests_failed,
                 tests_failed);
        if (tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    always @(posedge HCLK) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, only %0d of %0d transfers were checked",
                     cycles, tests_done, xfers.size());
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

/* verif/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
    import ahb_gpio_pkg::*;
#(
    parameter int n_red_leds   = 18,
    parameter int n_green_leds = 8,
    parameter int hex_width    = 32
)
(
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  logic [31:0]             HADDR,
    input  logic [1:0]              HTRANS,
    input  logic                    HWRITE,
    input  logic [31:0]             HRDATA,
    input  logic                    HREADY,
    input  logic                    HRESP,
    input  logic [n_red_leds-1:0]   red_leds,
    input  logic [n_green_leds-1:0] green_leds,
    input  logic [hex_width-1:0]    hex_digits,
    input  logic [31:0]             exp_rdata,     // expected data of the presented transfer.
    input  logic                    exp_check,
    output int                      tests_done,
    output int                      tests_failed
);

    // accepted address phases waiting for their data phase.
    bit          q_write[$];
    logic [31:0] q_addr[$];
    logic [31:0] q_exp[$];
    bit          q_check[$];

    logic [n_red_leds-1:0]   ref_red;
    logic [n_green_leds-1:0] ref_green;
    logic [hex_width-1:0]    ref_hex;

    bit          pins_pending;
    bit          pins_bad;
    bit          pins_write;
    int          pins_test;
    logic [31:0] pins_addr;

    bit          stalled;
    bit          stall_bad;

    bit          bad;
    bit          cur_write;
    bit          cur_check;
    logic [31:0] cur_addr;
    logic [31:0] cur_exp;
    int          test_idx;

    function automatic bit mismatch(input string name, input logic [31:0] want,
                                    input logic [31:0] got);
        mismatch = 1'b0;
        if (got !== want) begin
            $display("** Error: %s expected 0x%08h got 0x%08h", name, want, got);
            mismatch = 1'b1;
        end
    endfunction

    function automatic bit same_slave(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] region;
        region = a & region_mask;
        same_slave = (region == (b & region_mask)) &&
                     (region == gpio_base || region == ram_base);
    endfunction

    task automatic report(input int test, input bit write, input logic [31:0] addr,
                          input bit failed);
        tests_done = tests_done + 1;
        if (failed) tests_failed = tests_failed + 1;
        $display("test %0d %s 0x%08h %s", test, write ? "write" : "read ", addr,
                 failed ? "failed" : "ok");
    endtask

    // ########################################
    // data phase compare
    // ########################################

    always @(negedge HCLK) begin
        if (!HRESETn) begin
            q_write.delete();
            q_addr.delete();
            q_exp.delete();
            q_check.delete();
            ref_red      = '0;
            ref_green    = '0;
            ref_hex      = '0;
            pins_pending = 1'b0;
            stalled      = 1'b0;
            stall_bad    = 1'b0;
            test_idx     = 0;
            tests_done   = 0;
            tests_failed = 0;
        end else begin
            // pins settle one edge after the write's data phase.
            if (pins_pending) begin
                bad = pins_bad;
                bad = bad | mismatch("red_leds", 32'(ref_red), 32'(red_leds));
                bad = bad | mismatch("green_leds", 32'(ref_green), 32'(green_leds));
                bad = bad | mismatch("hex_digits", 32'(ref_hex), 32'(hex_digits));
                pins_pending = 1'b0;
                report(pins_test, pins_write, pins_addr, bad);
            end
            // a wait state only for a read right behind a write to the same slave.
            if (HREADY !== 1'b1) begin
                if (stalled || q_write.size() == 0 || !q_write[0] || HWRITE ||
                    !(HTRANS == htrans_nonseq || HTRANS == htrans_seq) ||
                    !same_slave(q_addr[0], HADDR)) begin
                    stall_bad = stall_bad | mismatch("HREADY", 32'h1, 32'(HREADY));
                end
                stalled = 1'b1;
            end else begin
                stalled = 1'b0;
            end
            if (HREADY === 1'b1) begin
                if (q_addr.size() > 0) begin
                    cur_write = q_write.pop_front();
                    cur_addr  = q_addr.pop_front();
                    cur_exp   = q_exp.pop_front();
                    cur_check = q_check.pop_front();
                    bad = stall_bad | mismatch("HRESP", 32'h0, 32'(HRESP));
                    stall_bad = 1'b0;
                    if (!cur_write) begin
                        bad = bad | mismatch("HRDATA", cur_exp, HRDATA);
                    end else if ((cur_addr & region_mask) == gpio_base) begin
                        case (cur_addr[reg_addr_width+1:2])
                            gpio_red_leds_idx:   ref_red   = cur_exp[n_red_leds-1:0];
                            gpio_green_leds_idx: ref_green = cur_exp[n_green_leds-1:0];
                            gpio_hex_idx:        ref_hex   = cur_exp[hex_width-1:0];
                            default:             ;
                        endcase
                    end
                    if (cur_check) begin
                        pins_pending = 1'b1;
                        pins_bad     = bad;
                        pins_write   = cur_write;
                        pins_addr    = cur_addr;
                        pins_test    = test_idx;
                    end else begin
                        report(test_idx, cur_write, cur_addr, bad);
                    end
                    test_idx = test_idx + 1;
                end
                if (HTRANS == htrans_nonseq || HTRANS == htrans_seq) begin
                    q_write.push_back(HWRITE);
                    q_addr.push_back(HADDR);
                    q_exp.push_back(exp_rdata);
                    q_check.push_back(exp_check);
                end
            end
        end
    end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 2
)
(
    output logic HCLK,
    output logic HRESETn
);

    initial begin
        HCLK = 1'b0;
        forever #(period_ns / 2) HCLK = ~HCLK;
    end

    initial begin
        HRESETn = 1'b0;
        repeat (reset_cycles) @(posedge HCLK);
        HRESETn <= 1'b1;                  // released on a rising edge.
    end

endmodule
